//--- common/l2_types_pkg.sv
package l2_types_pkg;

    // requester ports in priority order
    localparam int L1_CONNECTIONS = 4;

    localparam int L1_DCACHE_ID = 0;
    localparam int L1_ICACHE_ID = 1;
    localparam int L1_DMMU_ID = 2;
    localparam int L1_IMMU_ID = 3;

    // wide enough to name every requester port
    localparam int SUB_ID_W = 2;

    // both L2 queues share this depth
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // memory model size in 32-bit words
    localparam int MEM_WORDS = 1024;
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

    typedef logic [SUB_ID_W-1:0] sub_id_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0] fifo_cnt_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // request as seen on the L1 side, byte addressed
    typedef struct packed {
        logic [31:0] addr;
        logic rnw;
        logic [3:0] be;
        // burst length minus one
        logic [2:0] size;
        logic [31:0] data;
    } l1_request_t;

    // request entry in the L2 request queue, word addressed
    typedef struct packed {
        logic [29:0] addr;
        logic rnw;
        logic [3:0] be;
        logic [2:0] burst_size;
        sub_id_t sub_id;
    } l2_request_t;

    // one returned read word with the port it belongs to
    typedef struct packed {
        logic [31:0] rd_data;
        sub_id_t rd_sub_id;
    } l2_return_t;

endpackage

//--- l1_arbiter/l1_arbiter.sv
`timescale 1ns/1ns

module l1_arbiter (
    input logic clk,
    input logic rst,

    input logic [l2_types_pkg::L1_CONNECTIONS-1:0] req_valid,
    input l2_types_pkg::l1_request_t [l2_types_pkg::L1_CONNECTIONS-1:0] req,
    output logic [l2_types_pkg::L1_CONNECTIONS-1:0] ack,

    output l2_types_pkg::l2_request_t l2_req,
    output logic request_push,
    input logic request_full,

    output logic [31:0] wr_data,
    output logic wr_data_push,
    input logic data_full,

    input l2_types_pkg::l2_return_t l2_ret,
    input logic rd_data_valid,

    output logic [31:0] rsp_data,
    output logic [l2_types_pkg::L1_CONNECTIONS-1:0] rsp_valid
);

    logic push_ready;
    logic any_request;
    l2_types_pkg::sub_id_t grant_id;

    // the memory drains the two queues at different rates, so both need room
    assign push_ready = ~request_full & ~data_full;

    // lowest index wins
    always_comb begin
        grant_id = '0;
        any_request = 1'b0;
        for (int i = 0; i < l2_types_pkg::L1_CONNECTIONS; i++) begin
            if (req_valid[i] && !any_request) begin
                grant_id = l2_types_pkg::sub_id_t'(i);
                any_request = 1'b1;
            end
        end
    end

    always_comb begin
        ack = '0;
        ack[grant_id] = any_request & push_ready;
    end

    assign request_push = any_request & push_ready;

    // byte address becomes a word address and the port index rides along as sub_id
    always_comb begin
        l2_req.addr = req[grant_id].addr[31:2];
        l2_req.rnw = req[grant_id].rnw;
        l2_req.be = req[grant_id].be;
        l2_req.burst_size = req[grant_id].size;
        l2_req.sub_id = grant_id;
    end

    // only the data cache writes
    assign wr_data = req[l2_types_pkg::L1_DCACHE_ID].data;
    assign wr_data_push = ack[l2_types_pkg::L1_DCACHE_ID]
        & ~req[l2_types_pkg::L1_DCACHE_ID].rnw;

    // data is broadcast but valid only for the owning port
    assign rsp_data = l2_ret.rd_data;

    genvar p;
    generate
        for (p = 0; p < l2_types_pkg::L1_CONNECTIONS; p++) begin : g_rsp
            assign rsp_valid[p] = rd_data_valid
                && (l2_ret.rd_sub_id == l2_types_pkg::sub_id_t'(p));
        end
    endgenerate

    one_ack_at_a_time: assert property (
        @(posedge clk) disable iff (rst) $onehot0(ack)
    );

    // a granted write must reach both queues together
    write_pushes_both: assert property (
        @(posedge clk) disable iff (rst)
        request_push && !l2_req.rnw |-> wr_data_push && !data_full
    );

    generate
        for (p = 1; p < l2_types_pkg::L1_CONNECTIONS; p++) begin : g_read_only
            read_only_port: assert property (
                @(posedge clk) disable iff (rst) req_valid[p] |-> req[p].rnw
            );
        end
    endgenerate

endmodule

//--- l2_queue/l2_fifo.sv
`timescale 1ns/1ns

module l2_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input logic clk,
    input logic rst,

    input logic push,
    input payload_t push_data,
    output logic full,

    input logic pop,
    output payload_t head,
    output logic valid
);

    payload_t buffer [l2_types_pkg::FIFO_DEPTH];

    l2_types_pkg::fifo_ptr_t rd_ptr;
    l2_types_pkg::fifo_ptr_t wr_ptr;
    l2_types_pkg::fifo_cnt_t count;

    localparam l2_types_pkg::fifo_ptr_t LAST_SLOT =
        l2_types_pkg::fifo_ptr_t'(l2_types_pkg::FIFO_DEPTH - 1);

    assign full = (count == l2_types_pkg::fifo_cnt_t'(l2_types_pkg::FIFO_DEPTH));
    assign valid = (count != '0);
    assign head = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    );

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst) pop |-> valid
    );

endmodule

//--- src/l2_memory.sv
`timescale 1ns/1ns

module l2_memory (
    input logic clk,
    input logic rst,

    input l2_types_pkg::l2_request_t req_head,
    input logic req_valid,
    output logic req_pop,

    input logic [31:0] data_head,
    input logic data_valid,
    output logic data_pop,

    output l2_types_pkg::l2_return_t l2_ret,
    output logic rd_data_valid
);

    typedef enum logic {
        MEM_IDLE,
        MEM_BURST
    } mem_state_t;

    mem_state_t state;

    logic [31:0] mem [l2_types_pkg::MEM_WORDS];

    // words still to send after the current one
    logic [2:0] burst_cnt;
    l2_types_pkg::mem_addr_t cur_addr;
    l2_types_pkg::sub_id_t cur_sub_id;

    logic take_req;
    logic take_write;
    logic take_read;
    l2_types_pkg::mem_addr_t head_addr;

    // word address modulo the array size
    assign head_addr = req_head.addr[l2_types_pkg::MEM_ADDR_W-1:0];

    // a write waits at the head until its data word has arrived
    assign take_req = (state == MEM_IDLE) && req_valid && (req_head.rnw || data_valid);
    assign take_write = take_req && !req_head.rnw;
    assign take_read = take_req && req_head.rnw;

    assign req_pop = take_req;
    assign data_pop = take_write;

    always_ff @(posedge clk) begin
        if (take_write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_head.be[b]) begin
                    mem[head_addr][8*b +: 8] <= data_head[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MEM_IDLE;
            burst_cnt <= '0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (take_read) begin
                        state <= MEM_BURST;
                        burst_cnt <= req_head.burst_size;
                    end
                end
                MEM_BURST: begin
                    if (burst_cnt == '0) begin
                        state <= MEM_IDLE;
                    end else begin
                        burst_cnt <= burst_cnt - 1'b1;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    // address and tag of the burst in flight
    always_ff @(posedge clk) begin
        if (take_read) begin
            cur_addr <= head_addr;
            cur_sub_id <= req_head.sub_id;
        end else if (state == MEM_BURST) begin
            // wraps at the end of the array
            cur_addr <= cur_addr + 1'b1;
        end
    end

    assign rd_data_valid = (state == MEM_BURST);
    assign l2_ret.rd_data = mem[cur_addr];
    assign l2_ret.rd_sub_id = cur_sub_id;

    write_has_data: assert property (
        @(posedge clk) disable iff (rst)
        req_pop && !req_head.rnw |-> data_valid && data_pop
    );

endmodule

//--- src/l2_subsystem_top.sv
`timescale 1ns/1ns

module l2_subsystem_top (
    input logic clk,
    input logic rst,

    input logic [l2_types_pkg::L1_CONNECTIONS-1:0] req_valid,
    input l2_types_pkg::l1_request_t [l2_types_pkg::L1_CONNECTIONS-1:0] req,
    output logic [l2_types_pkg::L1_CONNECTIONS-1:0] ack,

    output logic [31:0] rsp_data,
    output logic [l2_types_pkg::L1_CONNECTIONS-1:0] rsp_valid
);

    // arbiter to queues
    l2_types_pkg::l2_request_t l2_req;
    logic request_push;
    logic request_full;
    logic [31:0] wr_data;
    logic wr_data_push;
    logic data_full;

    // queues to memory
    l2_types_pkg::l2_request_t req_head;
    logic req_head_valid;
    logic req_pop;
    logic [31:0] data_head;
    logic data_head_valid;
    logic data_pop;

    // read return path
    l2_types_pkg::l2_return_t l2_ret;
    logic rd_data_valid;

    l1_arbiter arbiter_i (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req(req),
        .ack(ack),
        .l2_req(l2_req),
        .request_push(request_push),
        .request_full(request_full),
        .wr_data(wr_data),
        .wr_data_push(wr_data_push),
        .data_full(data_full),
        .l2_ret(l2_ret),
        .rd_data_valid(rd_data_valid),
        .rsp_data(rsp_data),
        .rsp_valid(rsp_valid)
    );

    l2_fifo #(
        .payload_t(l2_types_pkg::l2_request_t)
    ) request_fifo_i (
        .clk(clk),
        .rst(rst),
        .push(request_push),
        .push_data(l2_req),
        .full(request_full),
        .pop(req_pop),
        .head(req_head),
        .valid(req_head_valid)
    );

    l2_fifo #(
        .payload_t(logic [31:0])
    ) data_fifo_i (
        .clk(clk),
        .rst(rst),
        .push(wr_data_push),
        .push_data(wr_data),
        .full(data_full),
        .pop(data_pop),
        .head(data_head),
        .valid(data_head_valid)
    );

    l2_memory memory_i (
        .clk(clk),
        .rst(rst),
        .req_head(req_head),
        .req_valid(req_head_valid),
        .req_pop(req_pop),
        .data_head(data_head),
        .data_valid(data_head_valid),
        .data_pop(data_pop),
        .l2_ret(l2_ret),
        .rd_data_valid(rd_data_valid)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

//--- dv/l2_subsystem_tb.sv
`timescale 1ns/1ns

module l2_subsystem_tb;

    // all reads and writes stay inside this window, which wraps past the last word
    localparam int REGION_BASE = 1000;
    localparam int REGION_WORDS = 72;
    localparam int TOTAL_REQUESTS = 348;
    localparam int TIMEOUT_CYCLES = TOTAL_REQUESTS * 20;

    typedef struct packed {
        logic [1:0] port;
        logic [31:0] data;
    } exp_word_t;

    logic clk;
    logic rst;
    logic [l2_types_pkg::L1_CONNECTIONS-1:0] req_valid;
    l2_types_pkg::l1_request_t [l2_types_pkg::L1_CONNECTIONS-1:0] req;
    logic [l2_types_pkg::L1_CONNECTIONS-1:0] ack;
    logic [31:0] rsp_data;
    logic [l2_types_pkg::L1_CONNECTIONS-1:0] rsp_valid;

    l2_types_pkg::l1_request_t pending [l2_types_pkg::L1_CONNECTIONS][$];
    exp_word_t exp_q [$];
    logic [31:0] ref_mem [l2_types_pkg::MEM_WORDS];
    int ack_port [$];
    int ack_cycle [$];
    logic [31:0] lfsr_state = 32'hfa2570d8;
    int cycle;
    int checks;
    int errors;
    int full_cycles;

    tb_clock_gen clk_gen_i (
        .clk(clk)
    );

    l2_subsystem_top dut_i (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req(req),
        .ack(ack),
        .rsp_data(rsp_data),
        .rsp_valid(rsp_valid)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // expected word after a byte-enabled write
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic int region_word(input int offset);
        return (REGION_BASE + offset) % l2_types_pkg::MEM_WORDS;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic queue_write(input int offset, input logic [3:0] be, input logic [31:0] data);
        l2_types_pkg::l1_request_t r;
        r.addr = 32'(region_word(offset)) << 2;
        r.rnw = 1'b0;
        r.be = be;
        r.size = 3'd0;
        r.data = data;
        pending[l2_types_pkg::L1_DCACHE_ID].push_back(r);
    endtask

    task automatic queue_read(input int p, input int offset, input logic [2:0] size);
        l2_types_pkg::l1_request_t r;
        r.addr = 32'(region_word(offset)) << 2;
        r.rnw = 1'b1;
        r.be = 4'hf;
        r.size = size;
        r.data = '0;
        pending[p].push_back(r);
    endtask

    // reference updated at the handshake and reads snapshot their words in request order
    task automatic record_ack(input int p, input l2_types_pkg::l1_request_t r);
        int word;
        exp_word_t e;
        word = int'(r.addr[31:2]) % l2_types_pkg::MEM_WORDS;
        if (!r.rnw) begin
            ref_mem[word] = merge_bytes(ref_mem[word], r.data, r.be);
        end else begin
            for (int k = 0; k <= int'(r.size); k++) begin
                e.port = 2'(p);
                e.data = ref_mem[(word + k) % l2_types_pkg::MEM_WORDS];
                exp_q.push_back(e);
            end
        end
        ack_port.push_back(p);
        ack_cycle.push_back(cycle);
    endtask

    task automatic wait_idle();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = (req_valid != '0) || (exp_q.size() != 0);
            for (int p = 0; p < l2_types_pkg::L1_CONNECTIONS; p++) begin
                if (pending[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s: %0d errors", name, errors - start_errors);
    endtask

    // one requester per port which holds its request until acked
    genvar gp;
    generate
        for (gp = 0; gp < l2_types_pkg::L1_CONNECTIONS; gp++) begin : g_drv
            logic drv_valid;
            l2_types_pkg::l1_request_t drv_req;

            assign req_valid[gp] = drv_valid;
            assign req[gp] = drv_req;

            initial begin
                drv_valid = 1'b0;
                drv_req = '0;
                forever begin
                    @(posedge clk);
                    #1;
                    if (pending[gp].size() > 0) begin
                        drv_req = pending[gp].pop_front();
                        drv_valid = 1'b1;
                        do begin
                            @(negedge clk);
                        end while (!ack[gp]);
                        record_ack(gp, drv_req);
                    end else begin
                        drv_valid = 1'b0;
                    end
                end
            end
        end
    endgenerate

    // compare every returned word against the expected queue
    always @(negedge clk) begin
        exp_word_t head;
        if (!rst && rsp_valid != '0) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("read data returned at %0t on ports %b with no read outstanding",
                         $time, rsp_valid);
            end else begin
                head = exp_q.pop_front();
                check_value(32'($countones(rsp_valid)), 32'd1, "rsp_valid bits set");
                check_value(32'(rsp_valid), 32'(1) << head.port, "rsp_valid port");
                check_value(rsp_data, head.data,
                            $sformatf("read data for port %0d", head.port));
            end
        end
    end

    // no grant while either queue is full
    always @(negedge clk) begin
        if (!rst && (dut_i.request_full || dut_i.data_full)) begin
            full_cycles++;
            check_value(32'(ack), 32'h0, "ack while a FIFO is full");
        end
    end

    initial begin
        cycle = 0;
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: run stopped after %0d cycles with requests still outstanding",
                 cycle);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int wr_off [16];
        int start_errors;
        int p;
        checks = 0;
        errors = 0;
        full_cycles = 0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // fill the window with full words, then partial writes and readback
        start_errors = errors;
        for (int k = 0; k < REGION_WORDS; k++) begin
            queue_write(k, 4'hf, rand_bits(32));
        end
        for (int k = 0; k < 16; k++) begin
            wr_off[k] = int'(rand_bits(6));
            queue_write(wr_off[k], 4'(rand_bits(4)), rand_bits(32));
        end
        for (int k = 0; k < 16; k++) begin
            queue_read(l2_types_pkg::L1_DCACHE_ID, wr_off[k], 3'd0);
        end
        wait_idle();
        report_test("1 write and readback", start_errors);

        // bursts of every length where most cross the top of the array
        start_errors = errors;
        for (int k = 0; k < 8; k++) begin
            queue_read(l2_types_pkg::L1_ICACHE_ID, 18 + k, 3'(k));
        end
        wait_idle();
        report_test("2 burst reads", start_errors);

        start_errors = errors;
        ack_port.delete();
        ack_cycle.delete();
        for (int k = 0; k < l2_types_pkg::L1_CONNECTIONS; k++) begin
            queue_read(k, 8 * k, 3'(k));
        end
        wait_idle();
        for (int k = 0; k < 4; k++) begin
            check_value(32'(ack_port[k]), 32'(k), "ack order");
            check_value(32'(ack_cycle[k] - ack_cycle[0]), 32'(k), "ack spacing");
        end
        report_test("3 simultaneous requests", start_errors);

        start_errors = errors;
        full_cycles = 0;
        for (int n = 0; n < 8; n++) begin
            for (int k = 0; k < l2_types_pkg::L1_CONNECTIONS; k++) begin
                queue_read(k, int'(rand_bits(6)), 3'd7);
            end
        end
        wait_idle();
        check_value(32'(full_cycles != 0), 32'd1, "request FIFO reached full");
        report_test("4 back-to-back bursts", start_errors);

        start_errors = errors;
        for (int n = 0; n < 200; n++) begin
            p = int'(rand_bits(2));
            if (p == l2_types_pkg::L1_DCACHE_ID && rand_bits(1) == 32'd1) begin
                queue_write(int'(rand_bits(6)), 4'(rand_bits(4)), rand_bits(32));
            end else begin
                queue_read(p, int'(rand_bits(6)), 3'(rand_bits(3)));
            end
        end
        wait_idle();
        report_test("5 random mix", start_errors);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
common/l2_types_pkg.sv
l1_arbiter/l1_arbiter.sv
l2_queue/l2_fifo.sv
src/l2_memory.sv
src/l2_subsystem_top.sv
dv/tb_clock_gen.sv
dv/l2_subsystem_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = l2_subsystem_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST FAIL
PASS_MSG  = TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
